// ==== logic/standby_pkg.sv ====
// Standby receive definitions
`default_nettype none

package standby_pkg;

  // Bus timer thresholds and counter
  localparam int unsigned TimerWidth = 20;

  // Target addressing
  localparam int unsigned AddrWidth = 7;

  // RX descriptor layout
  localparam int unsigned RxDescWidth = 32;
  localparam int unsigned DescCountWidth = 16;
  localparam int unsigned DescErrBit = 31;

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [TimerWidth-1:0] timer_t;
  typedef logic [7:0] rx_byte_t;
  typedef logic [RxDescWidth-1:0] rx_desc_t;

  // Reserved for CCCs, never acked in standby
  localparam addr_t BroadcastAddr = 7'h7E;

endpackage

`default_nettype wire

// ==== logic/queue_stage.sv ====
// Two-entry skid buffer
`timescale 1ns/1ps
`default_nettype none

module queue_stage #(
  parameter type payload_t = logic [7:0]
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     in_valid_i,
  output logic     in_ready_o,
  input  payload_t in_data_i,
  output logic     out_valid_o,
  input  logic     out_ready_i,
  output payload_t out_data_o
);

  logic     skid_valid_q;
  payload_t skid_data_q;
  logic     push;
  logic     load_out;

  assign in_ready_o = ~skid_valid_q;
  assign push       = in_valid_i & in_ready_o;
  // Output register is free when empty or being drained
  assign load_out   = ~out_valid_o | out_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      out_valid_o  <= 1'b0;
      skid_valid_q <= 1'b0;
    end else if (load_out) begin
      if (skid_valid_q) begin
        out_valid_o  <= 1'b1;
        skid_valid_q <= 1'b0;
      end else begin
        out_valid_o <= push;
      end
    end else if (push) begin
      skid_valid_q <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load_out) begin
      out_data_o <= skid_valid_q ? skid_data_q : in_data_i;
    end
    if (in_ready_o) begin
      skid_data_q <= in_data_i;
    end
  end

endmodule

`default_nettype wire

// ==== logic/bus_timers.sv ====
// Bus free and idle timers
`timescale 1ns/1ps
`default_nettype none

module bus_timers
  import standby_pkg::*;
(
  input  logic   clk_i,
  input  logic   rst_ni,
  input  logic   enable_i,
  input  logic   start_det_i,
  input  logic   stop_det_i,
  input  timer_t t_bus_free_i,
  input  timer_t t_bus_idle_i,
  output logic   bus_free_o,
  output logic   bus_idle_o
);

  timer_t cnt_q;
  logic   restart;

  // Any bus condition restarts the measurement
  assign restart = start_det_i | stop_det_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (!enable_i || restart) begin
      cnt_q <= '0;
    end else if (cnt_q != '1) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bus_free_o <= 1'b0;
      bus_idle_o <= 1'b0;
    end else if (!enable_i || restart) begin
      bus_free_o <= 1'b0;
      bus_idle_o <= 1'b0;
    end else begin
      bus_free_o <= (cnt_q >= t_bus_free_i);
      bus_idle_o <= (cnt_q >= t_bus_idle_i);
    end
  end

endmodule

`default_nettype wire

// ==== logic/target_rx_fsm.sv ====
// Target receive state machine
`timescale 1ns/1ps
`default_nettype none

module target_rx_fsm
  import standby_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     enable_i,
  input  logic     start_det_i,
  input  logic     stop_det_i,
  input  logic     rx_byte_valid_i,
  input  rx_byte_t rx_byte_i,
  input  logic     bus_free_i,
  input  addr_t    sta_addr_i,
  input  logic     sta_addr_valid_i,
  input  addr_t    dyn_addr_i,
  input  logic     dyn_addr_valid_i,
  output rx_byte_t bus_addr_o,
  output logic     bus_addr_valid_o,
  output logic     addr_ack_o,
  output logic     xfer_begin_o,
  output logic     data_valid_o,
  output rx_byte_t data_byte_o,
  output logic     xfer_end_o,
  output logic     xfer_in_progress_o
);

  typedef enum logic [2:0] {
    Unjoined,
    Idle,
    Address,
    Write,
    Ignore
  } state_e;

  state_e state_q, state_d;

  addr_t own_addr;
  logic  own_addr_valid;
  logic  addr_match;
  logic  bus_event;
  logic  addr_seen;
  logic  ack;
  logic  write_byte;
  logic  write_end;

  // Dynamic address takes priority over the static one
  assign own_addr_valid = dyn_addr_valid_i | sta_addr_valid_i;
  assign own_addr       = dyn_addr_valid_i ? dyn_addr_i : sta_addr_i;

  assign addr_match = own_addr_valid && (rx_byte_i[7:1] == own_addr) &&
                      (rx_byte_i[7:1] != BroadcastAddr) && !rx_byte_i[0];

  assign bus_event  = start_det_i | stop_det_i;
  assign addr_seen  = enable_i && (state_q == Address) && rx_byte_valid_i && !bus_event;
  assign ack        = addr_seen && addr_match;
  assign write_byte = enable_i && (state_q == Write) && rx_byte_valid_i && !bus_event;
  // A repeated start also closes the write
  assign write_end  = enable_i && (state_q == Write) && bus_event;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      Unjoined: begin
        if (bus_free_i) state_d = Idle;
      end
      Idle: begin
        if (start_det_i) state_d = Address;
      end
      Address: begin
        if (stop_det_i) begin
          state_d = Idle;
        end else if (start_det_i) begin
          state_d = Address;
        end else if (rx_byte_valid_i) begin
          state_d = addr_match ? Write : Ignore;
        end
      end
      Write, Ignore: begin
        if (stop_det_i) begin
          state_d = Idle;
        end else if (start_det_i) begin
          state_d = Address;
        end
      end
      default: state_d = Unjoined;
    endcase
    if (!enable_i) state_d = Unjoined;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= Unjoined;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bus_addr_o         <= '0;
      bus_addr_valid_o   <= 1'b0;
      addr_ack_o         <= 1'b0;
      data_valid_o       <= 1'b0;
      xfer_end_o         <= 1'b0;
      xfer_in_progress_o <= 1'b0;
    end else begin
      bus_addr_valid_o <= addr_seen;
      addr_ack_o       <= ack;
      data_valid_o     <= write_byte;
      xfer_end_o       <= write_end;
      if (addr_seen) bus_addr_o <= rx_byte_i;
      if (ack) begin
        xfer_in_progress_o <= 1'b1;
      end else if (stop_det_i || !enable_i) begin
        xfer_in_progress_o <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (write_byte) data_byte_o <= rx_byte_i;
  end

  // The ack opens the write transfer
  assign xfer_begin_o = addr_ack_o;

endmodule

`default_nettype wire

// ==== logic/descriptor_rx.sv ====
// RX byte and descriptor builder
`timescale 1ns/1ps
`default_nettype none

module descriptor_rx
  import standby_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     xfer_begin_i,
  input  logic     data_valid_i,
  input  rx_byte_t data_byte_i,
  input  logic     xfer_end_i,
  output logic     rx_queue_wvalid_o,
  input  logic     rx_queue_wready_i,
  output rx_byte_t rx_queue_wdata_o,
  output logic     rx_desc_queue_wvalid_o,
  input  logic     rx_desc_queue_wready_i,
  output rx_desc_t rx_desc_queue_wdata_o,
  output logic     rx_overflow_o
);

  logic [DescCountWidth-1:0] byte_cnt_q;
  logic                      err_q;
  logic                      data_ready;
  logic                      data_push;
  logic                      desc_ready;
  logic                      desc_push_q;
  rx_desc_t                  desc_word_q;

  assign data_push = data_valid_i & data_ready;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      byte_cnt_q <= '0;
      err_q      <= 1'b0;
    end else if (xfer_begin_i) begin
      byte_cnt_q <= '0;
      err_q      <= 1'b0;
    end else if (data_push) begin
      byte_cnt_q <= byte_cnt_q + 1'b1;
    end else if (data_valid_i) begin
      err_q <= 1'b1;
    end
  end

  // Descriptor is pushed one cycle after the transfer ends
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      desc_push_q <= 1'b0;
    end else begin
      desc_push_q <= xfer_end_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (xfer_end_i) begin
      desc_word_q                       <= '0;
      desc_word_q[DescCountWidth-1:0]   <= byte_cnt_q;
      desc_word_q[DescErrBit]           <= err_q;
    end
  end

  // Dropped bytes and dropped descriptors
  assign rx_overflow_o = (data_valid_i & ~data_ready) | (desc_push_q & ~desc_ready);

  queue_stage #(.payload_t(rx_byte_t)) u_data_stage (
    .clk_i,
    .rst_ni,
    .in_valid_i  (data_push),
    .in_ready_o  (data_ready),
    .in_data_i   (data_byte_i),
    .out_valid_o (rx_queue_wvalid_o),
    .out_ready_i (rx_queue_wready_i),
    .out_data_o  (rx_queue_wdata_o)
  );

  queue_stage #(.payload_t(rx_desc_t)) u_desc_stage (
    .clk_i,
    .rst_ni,
    .in_valid_i  (desc_push_q),
    .in_ready_o  (desc_ready),
    .in_data_i   (desc_word_q),
    .out_valid_o (rx_desc_queue_wvalid_o),
    .out_ready_i (rx_desc_queue_wready_i),
    .out_data_o  (rx_desc_queue_wdata_o)
  );

endmodule

`default_nettype wire

// ==== logic/controller_standby.sv ====
// I3C standby receive top
`timescale 1ns/1ps
`default_nettype none

module controller_standby
  import standby_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     standby_en_i,

  // Decoded bus events
  input  logic     start_det_i,
  input  logic     stop_det_i,
  input  logic     rx_byte_valid_i,
  input  rx_byte_t rx_byte_i,

  input  timer_t   t_bus_free_i,
  input  timer_t   t_bus_idle_i,

  input  addr_t    target_sta_addr_i,
  input  logic     target_sta_addr_valid_i,
  input  addr_t    target_dyn_addr_i,
  input  logic     target_dyn_addr_valid_i,

  // Status
  output logic     bus_free_o,
  output logic     bus_idle_o,
  output logic     addr_ack_o,
  output rx_byte_t bus_addr_o,
  output logic     bus_addr_valid_o,
  output logic     xfer_in_progress_o,

  // RX queues
  output logic     rx_queue_wvalid_o,
  input  logic     rx_queue_wready_i,
  output rx_byte_t rx_queue_wdata_o,
  output logic     rx_desc_queue_wvalid_o,
  input  logic     rx_desc_queue_wready_i,
  output rx_desc_t rx_desc_queue_wdata_o,
  output logic     rx_overflow_o
);

  logic     bus_free;
  logic     xfer_begin;
  logic     data_valid;
  rx_byte_t data_byte;
  logic     xfer_end;

  assign bus_free_o = bus_free;

  bus_timers u_bus_timers (
    .clk_i,
    .rst_ni,
    .enable_i     (standby_en_i),
    .start_det_i,
    .stop_det_i,
    .t_bus_free_i,
    .t_bus_idle_i,
    .bus_free_o   (bus_free),
    .bus_idle_o
  );

  target_rx_fsm u_target_rx_fsm (
    .clk_i,
    .rst_ni,
    .enable_i           (standby_en_i),
    .start_det_i,
    .stop_det_i,
    .rx_byte_valid_i,
    .rx_byte_i,
    .bus_free_i         (bus_free),
    .sta_addr_i         (target_sta_addr_i),
    .sta_addr_valid_i   (target_sta_addr_valid_i),
    .dyn_addr_i         (target_dyn_addr_i),
    .dyn_addr_valid_i   (target_dyn_addr_valid_i),
    .bus_addr_o,
    .bus_addr_valid_o,
    .addr_ack_o,
    .xfer_begin_o       (xfer_begin),
    .data_valid_o       (data_valid),
    .data_byte_o        (data_byte),
    .xfer_end_o         (xfer_end),
    .xfer_in_progress_o
  );

  descriptor_rx u_descriptor_rx (
    .clk_i,
    .rst_ni,
    .xfer_begin_i           (xfer_begin),
    .data_valid_i           (data_valid),
    .data_byte_i            (data_byte),
    .xfer_end_i             (xfer_end),
    .rx_queue_wvalid_o,
    .rx_queue_wready_i,
    .rx_queue_wdata_o,
    .rx_desc_queue_wvalid_o,
    .rx_desc_queue_wready_i,
    .rx_desc_queue_wdata_o,
    .rx_overflow_o
  );

endmodule

`default_nettype wire

// ==== tests/clk_rst_gen.sv ====
// Testbench clock and reset
`timescale 1ns/1ps
`default_nettype none

module clk_rst_gen (
  output logic clk_o,
  output logic rst_no
);

  localparam int ClkPeriod   = 100;
  localparam int ResetCycles = 4;

  initial begin
    clk_o = 1'b0;
    forever #(ClkPeriod / 2) clk_o = ~clk_o;
  end

  // Released on a falling edge, clear of the stimulus
  initial begin
    rst_no = 1'b0;
    #(ResetCycles * ClkPeriod) rst_no = 1'b1;
  end

endmodule

`default_nettype wire

// ==== tests/controller_standby_tb.sv ====
// Standby receive testbench
`timescale 1ns/1ps
`default_nettype none

module controller_standby_tb
  import standby_pkg::*;
();

  localparam int    DriveDelay   = 10;
  localparam int    ByteGap      = 4;
  localparam int    WaitLimit    = 200;
  localparam int    SettleCycles = 12;
  localparam addr_t StaAddr      = 7'h21;
  localparam addr_t DynAddr      = 7'h35;
  localparam addr_t OtherAddr    = 7'h12;

  typedef struct packed {
    logic [3:0]  test_id;
    rx_byte_t    addr_byte;
    logic [7:0]  num_bytes;
    logic [7:0]  rdy_pattern;
    logic        dyn_valid;
    logic        hold_desc;
    logic        release_desc;
    logic        exp_ack;
    logic [15:0] exp_count;
    logic        exp_err;
    logic        exp_desc;
    logic [3:0]  exp_drops;
  } row_t;

  logic clk_i;
  logic rst_ni;
  logic standby_en_i, start_det_i, stop_det_i, rx_byte_valid_i;
  rx_byte_t rx_byte_i;
  timer_t t_bus_free_i, t_bus_idle_i;
  addr_t target_sta_addr_i, target_dyn_addr_i;
  logic target_sta_addr_valid_i, target_dyn_addr_valid_i;
  logic bus_free_o, bus_idle_o, addr_ack_o, bus_addr_valid_o, xfer_in_progress_o;
  rx_byte_t bus_addr_o;
  logic rx_queue_wvalid_o, rx_queue_wready_i;
  rx_byte_t rx_queue_wdata_o;
  logic rx_desc_queue_wvalid_o, rx_desc_queue_wready_i;
  rx_desc_t rx_desc_queue_wdata_o;
  logic rx_overflow_o;

  row_t table_q[$];
  rx_byte_t exp_bytes[$];
  rx_byte_t got_bytes[$];
  rx_desc_t exp_descs[$];
  rx_desc_t got_descs[$];
  logic [7:0] rdy_pattern;
  logic [2:0] rdy_phase;
  int checks, errors;
  int addr_cnt, ack_cnt, overflow_cnt;
  rx_byte_t last_addr;
  logic xip_seen;
  logic [31:0] seed;

  clk_rst_gen u_clk_rst_gen (
    .clk_o  (clk_i),
    .rst_no (rst_ni)
  );

  controller_standby controller_standby_inst (.*);

  // Output monitor, sampled away from the rising edge
  always @(negedge clk_i) begin
    if (rst_ni) begin
      if (rx_queue_wvalid_o && rx_queue_wready_i) got_bytes.push_back(rx_queue_wdata_o);
      if (rx_desc_queue_wvalid_o && rx_desc_queue_wready_i) begin
        got_descs.push_back(rx_desc_queue_wdata_o);
      end
      if (rx_overflow_o) overflow_cnt++;
      if (addr_ack_o) ack_cnt++;
      if (bus_addr_valid_o) begin
        addr_cnt++;
        last_addr = bus_addr_o;
      end
      if (xfer_in_progress_o) xip_seen = 1'b1;
    end
  end

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic report_timeout(input string what);
    errors++;
    $display("Timed out waiting for %s", what);
  endtask

  // Data ready follows the row's pattern, one bit per cycle
  task automatic tick();
    @(posedge clk_i);
    #DriveDelay;
    rx_queue_wready_i = rdy_pattern[rdy_phase];
    rdy_phase = rdy_phase + 1'b1;
  endtask

  task automatic add_row(input int test_id, input rx_byte_t addr_byte, input int num_bytes,
                         input logic [7:0] pattern, input logic dyn_valid,
                         input logic hold_desc, input logic release_desc,
                         input logic exp_ack, input int exp_count, input logic exp_err,
                         input logic exp_desc, input int exp_drops);
    row_t row;
    row.test_id      = test_id[3:0];
    row.addr_byte    = addr_byte;
    row.num_bytes    = num_bytes[7:0];
    row.rdy_pattern  = pattern;
    row.dyn_valid    = dyn_valid;
    row.hold_desc    = hold_desc;
    row.release_desc = release_desc;
    row.exp_ack      = exp_ack;
    row.exp_count    = exp_count[15:0];
    row.exp_err      = exp_err;
    row.exp_desc     = exp_desc;
    row.exp_drops    = exp_drops[3:0];
    table_q.push_back(row);
  endtask

  task automatic build_table();
    // test, addr byte, bytes, ready, dyn, hold desc, release desc,
    // ack, count, err, desc, drops
    add_row(2, {DynAddr, 1'b0},       4, 8'hFF, 1, 0, 0, 1, 4, 0, 1, 0);
    add_row(2, {DynAddr, 1'b0},       6, 8'hAA, 1, 0, 0, 1, 6, 0, 1, 0);
    add_row(3, {StaAddr, 1'b0},       2, 8'hFF, 1, 0, 0, 0, 0, 0, 0, 0);
    add_row(3, {DynAddr, 1'b1},       1, 8'hFF, 1, 0, 0, 0, 0, 0, 0, 0);
    add_row(3, {OtherAddr, 1'b0},     2, 8'hFF, 1, 0, 0, 0, 0, 0, 0, 0);
    add_row(3, {BroadcastAddr, 1'b0}, 1, 8'hFF, 1, 0, 0, 0, 0, 0, 0, 0);
    add_row(3, {StaAddr, 1'b0},       3, 8'hFF, 0, 0, 0, 1, 3, 0, 1, 0);
    // Data stage full after two bytes
    add_row(4, {DynAddr, 1'b0},       5, 8'h00, 1, 0, 0, 1, 2, 1, 1, 3);
    add_row(5, {DynAddr, 1'b0},       0, 8'hFF, 1, 1, 0, 1, 0, 0, 1, 0);
    add_row(5, {DynAddr, 1'b0},       0, 8'hFF, 1, 1, 0, 1, 0, 0, 1, 0);
    add_row(5, {DynAddr, 1'b0},       0, 8'hFF, 1, 1, 1, 1, 0, 0, 0, 1);
  endtask

  task automatic send_transfer(input row_t row);
    logic [31:0] rnd;
    rx_byte_t    data;
    int          i;
    start_det_i = 1'b1;
    tick();
    start_det_i     = 1'b0;
    tick();
    rx_byte_i       = row.addr_byte;
    rx_byte_valid_i = 1'b1;
    tick();
    rx_byte_valid_i = 1'b0;
    for (i = 0; i < row.num_bytes; i++) begin
      repeat (ByteGap - 1) tick();
      rnd             = $urandom;
      data            = rnd[7:0];
      rx_byte_i       = data;
      rx_byte_valid_i = 1'b1;
      if (row.exp_ack && i < row.exp_count) exp_bytes.push_back(data);
      tick();
      rx_byte_valid_i = 1'b0;
    end
    repeat (ByteGap - 1) tick();
    stop_det_i = 1'b1;
    tick();
    stop_det_i = 1'b0;
  endtask

  task automatic drain_and_check(input logic descs_held);
    int   n;
    logic done;
    n    = 0;
    done = 1'b0;
    while (!done && n < WaitLimit) begin
      done = got_bytes.size() >= exp_bytes.size() &&
             (descs_held || got_descs.size() >= exp_descs.size());
      if (!done) tick();
      n++;
    end
    if (!done) report_timeout("data or descriptors on the RX queue outputs");
    repeat (SettleCycles) tick();
    compare("rx_queue_wvalid_o transfers", got_bytes.size(), exp_bytes.size());
    while (got_bytes.size() > 0 && exp_bytes.size() > 0) begin
      compare("rx_queue_wdata_o", got_bytes.pop_front(), exp_bytes.pop_front());
    end
    got_bytes.delete();
    exp_bytes.delete();
    if (!descs_held) begin
      compare("rx_desc_queue_wvalid_o transfers", got_descs.size(), exp_descs.size());
      while (got_descs.size() > 0 && exp_descs.size() > 0) begin
        compare("rx_desc_queue_wdata_o", got_descs.pop_front(), exp_descs.pop_front());
      end
      got_descs.delete();
      exp_descs.delete();
    end
  endtask

  task automatic run_row(input int idx);
    row_t     row;
    rx_desc_t desc;
    int       errs_before, a0, k0, o0;
    int       n;
    row         = table_q[idx];
    errs_before = errors;
    target_dyn_addr_valid_i = row.dyn_valid;
    if (row.hold_desc) rx_desc_queue_wready_i = 1'b0;
    rdy_pattern = row.rdy_pattern;
    a0 = addr_cnt;
    k0 = ack_cnt;
    o0 = overflow_cnt;
    xip_seen = 1'b0;
    send_transfer(row);
    desc                       = '0;
    desc[DescCountWidth-1:0]   = row.exp_count;
    desc[DescErrBit]           = row.exp_err;
    if (row.exp_desc) exp_descs.push_back(desc);
    // Descriptor queue stays stalled until the extra descriptor is dropped
    if (row.release_desc) begin
      for (n = 0; n < WaitLimit && overflow_cnt == o0; n++) tick();
      if (overflow_cnt == o0) report_timeout("the dropped descriptor");
      rx_desc_queue_wready_i = 1'b1;
    end
    rdy_pattern = 8'hFF;
    drain_and_check(row.hold_desc && !row.release_desc);
    compare("bus_addr_valid_o pulses", addr_cnt - a0, 1);
    compare("bus_addr_o", last_addr, row.addr_byte);
    compare("addr_ack_o pulses", ack_cnt - k0, row.exp_ack);
    compare("xfer_in_progress_o during transfer", xip_seen, row.exp_ack);
    compare("xfer_in_progress_o after stop", xfer_in_progress_o, 1'b0);
    compare("rx_overflow_o pulses", overflow_cnt - o0, row.exp_drops);
    $display("test %0d row %0d addr 0x%02h: %0d errors", row.test_id, idx,
             row.addr_byte, errors - errs_before);
  endtask

  // Bus is not joined until bus free has been seen
  task automatic join_gating();
    int n, errs_before, a0, k0;
    errs_before = errors;
    a0 = addr_cnt;
    k0 = ack_cnt;
    start_det_i = 1'b1;
    tick();
    start_det_i     = 1'b0;
    rx_byte_i       = {DynAddr, 1'b0};
    rx_byte_valid_i = 1'b1;
    tick();
    rx_byte_valid_i = 1'b0;
    repeat (ByteGap) tick();
    stop_det_i = 1'b1;
    tick();
    stop_det_i = 1'b0;
    compare("bus_addr_valid_o pulses", addr_cnt - a0, 0);
    compare("addr_ack_o pulses", ack_cnt - k0, 0);
    for (n = 0; n < WaitLimit && !bus_free_o; n++) tick();
    if (!bus_free_o) report_timeout("bus_free_o after the stop");
    for (n = 0; n < WaitLimit && !bus_idle_o; n++) tick();
    if (!bus_idle_o) report_timeout("bus_idle_o after the stop");
    $display("test 1 join gating: %0d errors", errors - errs_before);
  endtask

  initial begin
    int n;
    seed = $urandom(50);
    standby_en_i            = 1'b1;
    start_det_i             = 1'b0;
    stop_det_i              = 1'b0;
    rx_byte_valid_i         = 1'b0;
    rx_byte_i               = '0;
    t_bus_free_i            = 20'd16;
    t_bus_idle_i            = 20'd40;
    target_sta_addr_i       = StaAddr;
    target_sta_addr_valid_i = 1'b1;
    target_dyn_addr_i       = DynAddr;
    target_dyn_addr_valid_i = 1'b1;
    rx_queue_wready_i       = 1'b1;
    rx_desc_queue_wready_i  = 1'b1;
    rdy_pattern = 8'hFF;
    rdy_phase   = '0;
    checks = 0;
    errors = 0;
    addr_cnt = 0;
    ack_cnt = 0;
    overflow_cnt = 0;
    xip_seen = 1'b0;
    build_table();
    for (n = 0; n < WaitLimit && rst_ni !== 1'b1; n++) tick();
    if (rst_ni !== 1'b1) report_timeout("reset release");
    tick();
    join_gating();
    for (n = 0; n < table_q.size(); n++) run_row(n);
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== controller_standby.f ====
logic/standby_pkg.sv
logic/queue_stage.sv
logic/bus_timers.sv
logic/target_rx_fsm.sv
logic/descriptor_rx.sv
logic/controller_standby.sv
tests/clk_rst_gen.sv
tests/controller_standby_tb.sv

// ==== Bender.yml ====
package:
  name: controller_standby

sources:
  - logic/standby_pkg.sv
  - logic/queue_stage.sv
  - logic/bus_timers.sv
  - logic/target_rx_fsm.sv
  - logic/descriptor_rx.sv
  - logic/controller_standby.sv
  - target: test
    files:
      - tests/clk_rst_gen.sv
      - tests/controller_standby_tb.sv
